//--- hw/spawnPkg.sv
package spawnPkg;

	// Random word width. Twelve bits keeps a full period short enough to walk in simulation
	localparam int lfsrLen = 12;

	// The board is a 640x480 screen cut into 20-pixel cells
	localparam int boardCols = 32;
	localparam int boardRows = 24;

	// Index widths for column and row
	localparam int colBits = $clog2(boardCols);
	localparam int rowBits = $clog2(boardRows);

	// One board cell with the column in the upper field and the row in the lower field
	typedef struct packed
	{
		logic [colBits-1:0] col;
		logic [rowBits-1:0] row;
	} cellPosT;

endpackage

//--- hw/lfsr.sv
`timescale 1ns/1ps

// Fibonacci shift register that shifts toward the top bit.
// The new bit 0 is the parity of the tapped bits.
// The start value is kept so that a full trip round the period can be seen
module lfsr #(
	parameter int length = spawnPkg::lfsrLen
) (
	input  logic              Clk,
	input  logic              rstN,
	input  logic              step,
	input  logic              loadSeed,
	input  logic [length-1:0] seed,
	output logic [length-1:0] word,
	output logic              wrapped
);

	logic [length-1:0] state; // Working value
	logic [length-1:0] startVal; // Value the current run began from
	logic [length-1:0] seedFixed; // Seed with the all-zero case removed
	logic              shiftIn; // Feedback bit

	// Maximal-length tap sets for widths 2 to 24, one bit per tapped stage
	function automatic logic [length-1:0] tapMask();
		logic [23:0] mask;
		case (length)
			2:       mask = 24'h000003;
			3:       mask = 24'h000006;
			4:       mask = 24'h00000C;
			5:       mask = 24'h000014;
			6:       mask = 24'h000030;
			7:       mask = 24'h000060;
			8:       mask = 24'h0000B8;
			9:       mask = 24'h000110;
			10:      mask = 24'h000240;
			11:      mask = 24'h000500;
			12:      mask = 24'h000E08; // Bits 11, 10, 9 and 3
			13:      mask = 24'h001C80;
			14:      mask = 24'h003802;
			15:      mask = 24'h006000;
			16:      mask = 24'h00D008;
			17:      mask = 24'h012000;
			18:      mask = 24'h020400;
			19:      mask = 24'h072000;
			20:      mask = 24'h090000;
			21:      mask = 24'h140000;
			22:      mask = 24'h300000;
			23:      mask = 24'h420000;
			24:      mask = 24'hE10000;
			default: mask = 24'h000000;
		endcase
		return mask[length-1:0];
	endfunction

	assign shiftIn = ^(state & tapMask());

	// An all-zero state would never leave zero, so it becomes 1
	assign seedFixed = (seed == '0) ? length'(1) : seed;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= length'(1);
			startVal <= length'(1);
		end
		else if (loadSeed)
		begin
			state    <= seedFixed; // Load wins over a step in the same cycle
			startVal <= seedFixed;
		end
		else if (step)
		begin
			state <= {state[length-2:0], shiftIn};
		end
	end

	assign word = state;

	// High once the register is back where it started
	assign wrapped = (state == startVal);

endmodule

//--- hw/cellMapper.sv
`timescale 1ns/1ps

// Maps a random word onto a board cell.
// Column comes from the low bits, row from the bits just above it.
// Any column value is legal on a 32-wide board, but only rows below the board
// height are, so words landing on the missing rows are flagged off-board
module cellMapper (
	input  logic [spawnPkg::lfsrLen-1:0] word,
	output spawnPkg::cellPosT            cand,
	output logic                         onBoard
);

	logic [spawnPkg::colBits-1:0] colSlice; // Word bits 4 to 0
	logic [spawnPkg::rowBits-1:0] rowSlice; // Word bits 9 to 5

	assign colSlice = word[spawnPkg::colBits-1:0];
	assign rowSlice = word[spawnPkg::colBits+spawnPkg::rowBits-1:spawnPkg::colBits];

	always_comb
	begin
		cand.col = colSlice;
		cand.row = rowSlice;
	end

	// Rows 24 to 31 exist in the word but not on the screen
	assign onBoard = (rowSlice < spawnPkg::rowBits'(spawnPkg::boardRows));

endmodule

//--- hw/foodPlacer.sv
`timescale 1ns/1ps

// Search controller for a free food cell.
// IDLE waits for a request, SEARCH walks the random sequence until a word
// lands on the board, PROBE asks the outside world whether that cell is taken
module foodPlacer (
	input  logic              Clk,
	input  logic              rstN,
	input  logic              request,
	input  logic              loadSeed,
	input  spawnPkg::cellPosT cand,
	input  logic              onBoard,
	input  logic              wrapped,
	input  logic              probeOccupied,
	output logic              step,
	output logic              loadEnable,
	output logic              busy,
	output spawnPkg::cellPosT probePos,
	output spawnPkg::cellPosT foodPos,
	output logic              placed,
	output logic              noRoom
);

	typedef enum logic [1:0]
	{
		IDLE,
		SEARCH,
		PROBE
	} stateT;

	stateT state;
	stateT stateNext;
	logic  idle; // No search running
	logic  accept; // Request taken this cycle
	logic  takeCand; // Current word is probed next
	logic  cellFree; // Probed cell answered free
	logic  giveUp; // Whole period walked without success

	assign idle = (state == IDLE);

	// A seed load in the same cycle takes priority and the request is dropped.
	// Otherwise the search would start on the start value and give up at once
	assign accept = request && idle && !loadSeed;

	assign loadEnable = loadSeed && idle; // Seed changes only between searches

	assign giveUp   = (state == SEARCH) && wrapped;
	assign takeCand = (state == SEARCH) && !wrapped && onBoard;
	assign cellFree = (state == PROBE) && !probeOccupied;

	always_comb
	begin
		stateNext = state;
		step      = 1'b0;
		case (state)
			IDLE:
			begin
				if (accept)
				begin
					step      = 1'b1; // Move off the current word before looking
					stateNext = SEARCH;
				end
			end
			SEARCH:
			begin
				if (wrapped)
				begin
					stateNext = IDLE;
				end
				else if (onBoard)
				begin
					stateNext = PROBE; // Hold the word while it is probed
				end
				else
				begin
					step = 1'b1;
				end
			end
			PROBE:
			begin
				if (probeOccupied)
				begin
					// Leave the taken word behind, or SEARCH would pick it again
					step      = 1'b1;
					stateNext = SEARCH;
				end
				else
				begin
					stateNext = IDLE;
				end
			end
			default:
			begin
				stateNext = IDLE;
			end
		endcase
	end

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= stateNext;
		end
	end

	// Result strobes line up with the cycle where busy drops
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			placed <= 1'b0;
			noRoom <= 1'b0;
		end
		else
		begin
			placed <= cellFree;
			noRoom <= giveUp;
		end
	end

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			probePos <= '0;
			foodPos  <= '0;
		end
		else
		begin
			if (takeCand)
			begin
				probePos <= cand; // Outside world answers from this next cycle
			end
			if (cellFree)
			begin
				foodPos <= probePos;
			end
		end
	end

	assign busy = !idle;

endmodule

//--- hw/foodSpawner.sv
`timescale 1ns/1ps

// Food spawning subsystem.
// The random source feeds the cell mapper, and the controller steers both
// and talks to the board occupancy lookup outside
module foodSpawner (
	input  logic                         Clk,
	input  logic                         rstN,
	input  logic [spawnPkg::lfsrLen-1:0] seed,
	input  logic                         loadSeed,
	input  logic                         request,
	input  logic                         probeOccupied,
	output logic                         busy,
	output spawnPkg::cellPosT            probePos,
	output spawnPkg::cellPosT            foodPos,
	output logic                         placed,
	output logic                         noRoom
);

	logic [spawnPkg::lfsrLen-1:0] word; // Current random word
	logic                         wrapped; // Register back at its start value
	logic                         step; // Advance the register
	logic                         loadEnable; // Seed load allowed through
	spawnPkg::cellPosT            cand; // Cell the current word points at
	logic                         onBoard; // Candidate row is on screen

	lfsr #(
		.length(spawnPkg::lfsrLen)
	) u_lfsr (
		.Clk     (Clk),
		.rstN    (rstN),
		.step    (step),
		.loadSeed(loadEnable), // Only reaches the register while idle
		.seed    (seed),
		.word    (word),
		.wrapped (wrapped)
	);

	cellMapper u_cellMapper (
		.word   (word),
		.cand   (cand),
		.onBoard(onBoard)
	);

	foodPlacer u_foodPlacer (
		.Clk          (Clk),
		.rstN         (rstN),
		.request      (request),
		.loadSeed     (loadSeed),
		.cand         (cand),
		.onBoard      (onBoard),
		.wrapped      (wrapped),
		.probeOccupied(probeOccupied),
		.step         (step),
		.loadEnable   (loadEnable),
		.busy         (busy),
		.probePos     (probePos),
		.foodPos      (foodPos),
		.placed       (placed),
		.noRoom       (noRoom)
	);

endmodule

//--- dv/foodSpawnerTb.sv
`timescale 1ns/1ps

module foodSpawnerTb;

	// Two full-period searches of at most 8190 cycles each, plus the short tests
	localparam int maxCycles = 40000;
	localparam int emptyBoard = 0;
	localparam int fullBoard = 1;
	localparam int randomBoard = 2;

	logic                         Clk = 1'b0;
	logic                         rstN;
	logic [spawnPkg::lfsrLen-1:0] seed;
	logic                         loadSeed;
	logic                         request;
	logic                         probeOccupied;
	logic                         busy;
	spawnPkg::cellPosT            probePos;
	spawnPkg::cellPosT            foodPos;
	logic                         placed;
	logic                         noRoom;

	logic        occGrid [spawnPkg::boardCols][spawnPkg::boardRows]; // Cells taken by the snake
	logic [11:0] modelWord; // Reference register value
	logic [11:0] modelStart; // Value the reference run began from
	logic [31:0] lcgState = 32'h8e21;
	int          resultCount = 0; // Count of placed and noRoom pulses
	int          cycleCount = 0;

	foodSpawner u_foodSpawner (.*);

	always #2 Clk = ~Clk;

	// The board memory answers in the same cycle
	assign probeOccupied = occGrid[probePos.col][probePos.row];

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (rstN && (placed || noRoom))
			resultCount <= resultCount + 1;
		if (cycleCount >= maxCycles)
		begin
			$display("Timeout: tests still running after %0d cycles", cycleCount);
			failAndStop();
		end
	end

	assert property (@(posedge Clk) disable iff (!rstN) !(placed && noRoom))
	else reportFailure("placed and noRoom pulsed in the same cycle");

	assert property (@(posedge Clk) disable iff (!rstN)
		(placed || noRoom) |-> (!busy && $past(busy)))
	else reportFailure("result strobe not aligned with busy falling");

	assert property (@(posedge Clk) disable iff (!rstN)
		$past(request && !busy && !loadSeed) |-> busy)
	else reportFailure("busy did not rise after an accepted request");

	// A cell that answered occupied must never be the one placed
	assert property (@(posedge Clk) disable iff (!rstN) placed |-> !$past(probeOccupied))
	else reportFailure("food placed on a cell that answered occupied");

	task automatic failAndStop();
		$display("Some tests failed");
		$fatal(1, "Stopping at first failure");
	endtask

	task automatic reportFailure(input string what);
		$display("Error: %s", what);
		failAndStop();
	endtask

	task automatic reportMismatch(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("** Error: %s expected %0h actual %0h", testName, expected, actual);
		failAndStop();
	endtask

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Shifts toward the top bit and feeds back bits 11, 10, 9 and 3 combined
	function automatic logic [11:0] lfsrNext(input logic [11:0] w);
		return {w[10:0], w[11] ^ w[10] ^ w[9] ^ w[3]};
	endfunction

	// Walks the reference sequence to the first free on-board cell or back to the start
	task automatic predictFood(output bit expNoRoom, output spawnPkg::cellPosT expPos);
		spawnPkg::cellPosT cand;
		bit                done;
		expNoRoom = 1'b0;
		expPos    = '0;
		done      = 1'b0;
		while (!done)
		begin
			modelWord = lfsrNext(modelWord);
			cand.col  = modelWord[4:0];
			cand.row  = modelWord[9:5];
			if (modelWord == modelStart)
			begin
				expNoRoom = 1'b1;
				done      = 1'b1;
			end
			else if (cand.row < 5'(spawnPkg::boardRows) && !occGrid[cand.col][cand.row])
			begin
				expPos = cand;
				done   = 1'b1;
			end
		end
	endtask

	task automatic fillBoard(input int mode);
		spawnPkg::cellPosT pos;
		for (int i = 0; i < 1024; i++)
		begin
			pos      = 10'(i);
			lcgState = lcgStep(lcgState);
			if (pos.row < 5'(spawnPkg::boardRows))
				occGrid[pos.col][pos.row] = (mode == fullBoard) ||
					(mode == randomBoard && lcgState[16]);
		end
	endtask

	task automatic loadNewSeed(input logic [11:0] value);
		@(posedge Clk);
		seed     <= value;
		loadSeed <= 1'b1;
		@(posedge Clk);
		loadSeed   <= 1'b0;
		modelStart = (value == '0) ? 12'd1 : value; // Zero would lock the register
		modelWord  = modelStart;
	endtask

	task automatic checkQuiet(input string phase, input int cycles);
		repeat (cycles)
		begin
			@(negedge Clk);
			assert (!busy && !placed && !noRoom)
			else reportFailure({"busy or a result strobe active ", phase});
		end
	endtask

	// pokeKind 1 repeats the request and 2 loads another seed while the search runs
	task automatic runRequest(input string testName, input int pokeKind);
		bit                expNoRoom;
		spawnPkg::cellPosT expPos;
		int                expCount;
		predictFood(expNoRoom, expPos);
		expCount = resultCount + 1;
		@(posedge Clk);
		request <= 1'b1;
		@(posedge Clk);
		request <= 1'b0;
		if (pokeKind != 0)
		begin
			@(posedge Clk);
			request  <= (pokeKind == 1);
			loadSeed <= (pokeKind == 2);
			seed     <= ~modelStart;
			@(posedge Clk);
			request  <= 1'b0;
			loadSeed <= 1'b0;
		end
		@(negedge Clk);
		while (!(placed || noRoom))
			@(negedge Clk);
		if (expNoRoom)
		begin
			assert (noRoom && !placed)
			else reportFailure({testName, ": expected noRoom but food was placed"});
		end
		else
		begin
			assert (placed && !noRoom)
			else reportFailure({testName, ": expected placed but got noRoom"});
			assert (foodPos == expPos)
			else reportMismatch(testName, 32'(expPos), 32'(foodPos));
			assert (probePos == expPos)
			else reportMismatch({testName, " probePos"}, 32'(expPos), 32'(probePos));
		end
		@(negedge Clk);
		assert (resultCount == expCount)
		else reportMismatch({testName, " result count"}, expCount, resultCount);
		assert (!busy && !placed && !noRoom)
		else reportFailure({testName, ": busy or strobe still high after the result"});
	endtask

	initial
	begin
		logic [11:0]       repeatSeed;
		spawnPkg::cellPosT firstPos;
		rstN       <= 1'b0;
		request    <= 1'b0;
		loadSeed   <= 1'b0;
		seed       <= '0;
		modelWord  = 12'd1; // Register value after reset
		modelStart = 12'd1;
		fillBoard(emptyBoard);
		repeat (2) @(posedge Clk);
		rstN <= 1'b1;

		checkQuiet("after reset", 4);
		assert (foodPos == '0 && probePos == '0)
		else reportFailure("foodPos or probePos not zero after reset");

		runRequest("resetSeed", 0);
		loadNewSeed(12'h000);
		runRequest("zeroSeed", 0);
		for (int i = 0; i < 3; i++)
		begin
			lcgState = lcgStep(lcgState);
			loadNewSeed(lcgState[27:16]);
			repeat (3) runRequest("emptyBoard", 0);
		end

		fillBoard(randomBoard);
		for (int i = 0; i < 8; i++)
			runRequest("randomBoard", 0);

		lcgState   = lcgStep(lcgState);
		repeatSeed = lcgState[27:16];
		loadNewSeed(repeatSeed);
		runRequest("seedRepeat", 0);
		firstPos = foodPos;
		loadNewSeed(repeatSeed);
		runRequest("loadWhileBusy", 2);
		assert (foodPos == firstPos)
		else reportMismatch("seedRepeat", 32'(firstPos), 32'(foodPos));
		runRequest("afterBusyLoad", 0);
		runRequest("requestWhileBusy", 1);
		checkQuiet("after an ignored request", 4);

		fillBoard(fullBoard);
		runRequest("fullBoard", 0);
		runRequest("fullBoardBusyRequest", 1);
		checkQuiet("after a full board search", 4);

		$display("All tests passed");
		$finish;
	end

endmodule

//--- sim.f
hw/spawnPkg.sv
hw/lfsr.sv
hw/cellMapper.sv
hw/foodPlacer.sv
hw/foodSpawner.sv
dv/foodSpawnerTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the food spawner testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module foodSpawnerTb --Mdir obj_dir -f sim.f
buildStatus=$?
if [ $buildStatus -ne 0 ]
then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

./obj_dir/VfoodSpawnerTb > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]
then
	echo "Simulation ended with status $runStatus"
	exit 1
fi

if grep -qx "All tests passed" "$logFile"
then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1
